// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       = tb_cam_bist_top
FILELIST  = cam_bist_top.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_LOG   = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@if grep -q "Verification failed" $(SIM_LOG); then exit 1; fi
	@grep -q "Verification passed" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

// File: cam_bist_top.f
verilog/cam_bist_pkg.sv
verilog/bcam_array.sv
verilog/cam_bist_counter.sv
verilog/cam_bist_inhandler.sv
verilog/cam_bist_fsm.sv
verilog/cam_bist_regs.sv
verilog/cam_bist_top.sv
sim/tb_cam_bist_top.sv

// File: sim/tb_cam_bist_top.sv
module tb_cam_bist_top import cam_bist_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // Cycles allowed per handshake and polls allowed for the BIST run
   localparam int wait_limit = 50;
   localparam int poll_limit = 200;

   logic       bist_clk;
   logic       rst_b;
   logic       awvalid;
   logic       awready;
   axi_addr_t  awaddr;
   logic       wvalid;
   logic       wready;
   axi_data_t  wdata;
   logic [3:0] wstrb;
   logic       bvalid;
   logic       bready;
   logic [1:0] bresp;
   logic       arvalid;
   logic       arready;
   axi_addr_t  araddr;
   logic       rvalid;
   logic       rready;
   axi_data_t  rdata;
   logic [1:0] rresp;

   int          errors;
   int          checks;
   logic [15:0] lfsr;
   cam_data_t   words [cam_entries];

   cam_bist_top uut (.*);

   always #20 bist_clk = ~bist_clk;

   // --------------------------------------------------
   // Bus protocol checks
   // --------------------------------------------------
   a_bvalid_hold: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bvalid && !bready |=> bvalid)
   else begin
      errors++;
      $display("Write response dropped before bready");
   end

   a_rdata_hold: assert property (@(posedge bist_clk) disable iff (!rst_b)
      rvalid && !rready |=> rvalid && $stable(rdata))
   else begin
      errors++;
      $display("Read data dropped or changed before rready");
   end

   // No second transaction while a response is pending
   a_no_aw_in_b: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bvalid |-> !awready && !wready)
   else begin
      errors++;
      $display("Write address or data accepted while a write response was pending");
   end

   a_no_ar_in_r: assert property (@(posedge bist_clk) disable iff (!rst_b)
      rvalid |-> !arready)
   else begin
      errors++;
      $display("Read address accepted while read data was pending");
   end

   // --------------------------------------------------
   // Helpers
   // --------------------------------------------------
   // Galois LFSR stepped once per bit taken
   function automatic axi_data_t next_random(input int nbits);
      axi_data_t value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         value = {value[30:0], lfsr[0]};
      end
      return value;
   endfunction

   task automatic expect_value(input string name, input axi_data_t got, input axi_data_t exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("Timeout while waiting for %s", what);
      finish_run();
   endtask

   task automatic write_reg(input axi_addr_t addr, input axi_data_t data, input int stall);
      int cycles;
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wstrb   <= 4'hF;
      bready  <= (stall == 0);
      // AW and W are taken in the same cycle
      cycles = 0;
      do begin
         @(posedge bist_clk);
         cycles++;
      end while (!(awready && wready) && cycles < wait_limit);
      if (!(awready && wready)) report_timeout("write address and data ready");
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      cycles = 0;
      do begin
         @(posedge bist_clk);
         cycles++;
      end while (!bvalid && cycles < wait_limit);
      if (!bvalid) report_timeout("write response");
      expect_value("bresp", axi_data_t'(bresp), 32'h0);
      if (stall > 0) begin
         // Offer a second write while the response is held
         awvalid <= 1'b1;
         wvalid  <= 1'b1;
         repeat (stall) begin
            @(posedge bist_clk);
            expect_value("bvalid", axi_data_t'(bvalid), 32'h1);
         end
         awvalid <= 1'b0;
         wvalid  <= 1'b0;
         bready  <= 1'b1;
         @(posedge bist_clk);
      end
   endtask

   task automatic read_reg(input axi_addr_t addr, input int stall, output axi_data_t data);
      int cycles;
      arvalid <= 1'b1;
      araddr  <= addr;
      rready  <= (stall == 0);
      cycles = 0;
      do begin
         @(posedge bist_clk);
         cycles++;
      end while (!arready && cycles < wait_limit);
      if (!arready) report_timeout("read address ready");
      arvalid <= 1'b0;
      cycles = 0;
      do begin
         @(posedge bist_clk);
         cycles++;
      end while (!rvalid && cycles < wait_limit);
      if (!rvalid) report_timeout("read data");
      data = rdata;
      expect_value("rresp", axi_data_t'(rresp), 32'h0);
      if (stall > 0) begin
         // Another address offered that must not replace the held data
         arvalid <= 1'b1;
         araddr  <= (addr == reg_status_addr) ? reg_ctrl_addr : reg_status_addr;
         repeat (stall) begin
            @(posedge bist_clk);
            expect_value("rvalid", axi_data_t'(rvalid), 32'h1);
            expect_value("rdata", rdata, data);
         end
         arvalid <= 1'b0;
         rready  <= 1'b1;
         @(posedge bist_clk);
      end
   endtask

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      axi_data_t rd;
      cam_data_t cand;
      cam_data_t bg;
      logic      fresh;
      int        polls;
      bist_clk = 1'b0;
      rst_b    = 1'b0;
      awvalid  = 1'b0;
      awaddr   = '0;
      wvalid   = 1'b0;
      wdata    = '0;
      wstrb    = '0;
      bready   = 1'b0;
      arvalid  = 1'b0;
      araddr   = '0;
      rready   = 1'b0;
      errors   = 0;
      checks   = 0;
      lfsr     = 16'd53327;
      repeat (10) @(posedge bist_clk);
      rst_b  <= 1'b1;
      bready <= 1'b1;
      rready <= 1'b1;
      @(posedge bist_clk);

      // Idle status and all entries zero so key 0 hits everywhere
      read_reg(reg_status_addr, 0, rd);
      expect_value("status", rd, 32'h0);
      write_reg(reg_key_addr, 32'h0, 0);
      read_reg(reg_match_addr, 0, rd);
      expect_value("match", rd, 32'h0000FFFF);

      // Distinct random words in every entry
      for (int i = 0; i < cam_entries; i++) begin
         do begin
            cand  = cam_data_t'(next_random(cam_width));
            fresh = 1'b1;
            for (int j = 0; j < i; j++) begin
               if (words[j] == cand) fresh = 1'b0;
            end
         end while (!fresh);
         words[i] = cand;
         write_reg(reg_wdata_addr, {12'h000, cam_addr_t'(i), cand}, 0);
      end

      // One hit per written word with back-pressure on a few accesses
      for (int i = 0; i < cam_entries; i++) begin
         write_reg(reg_key_addr, {16'h0000, words[i]}, (i == 5) ? 4 : 0);
         read_reg(reg_match_addr, (i == 9) ? 5 : 0, rd);
         expect_value("match", rd, axi_data_t'(1) << i);
      end

      // Word absent from the array
      do begin
         cand  = cam_data_t'(next_random(cam_width));
         fresh = 1'b1;
         for (int j = 0; j < cam_entries; j++) begin
            if (words[j] == cand) fresh = 1'b0;
         end
      end while (!fresh);
      write_reg(reg_key_addr, {16'h0000, cand}, 0);
      read_reg(reg_match_addr, 0, rd);
      expect_value("match", rd, 32'h0);
      read_reg(reg_wdata_addr, 5, rd);
      expect_value("wdata_reg", rd, {12'h000, 4'hF, words[cam_entries-1]});

      // --------------------------------------------------
      // BIST run
      // --------------------------------------------------
      bg = cam_data_t'(next_random(cam_width));
      write_reg(reg_ctrl_addr, {bg, 16'h0001}, 0);
      read_reg(reg_status_addr, 0, rd);
      expect_value("status.busy", axi_data_t'(rd[0]), 32'h1);
      // Second pass writes over while walking searches still run
      repeat (72) @(posedge bist_clk);
      write_reg(reg_wdata_addr, {12'h000, 4'h5, bg}, 0);
      read_reg(reg_status_addr, 0, rd);
      expect_value("status.busy", axi_data_t'(rd[0]), 32'h1);

      polls = 0;
      do begin
         read_reg(reg_status_addr, 0, rd);
         polls++;
      end while (!rd[1] && polls < poll_limit);
      if (!rd[1]) report_timeout("BIST done");
      // Done only with no fail and a zero count
      expect_value("status", rd, 32'h00000002);

      // Array left holding the inverted background
      write_reg(reg_key_addr, {16'h0000, ~bg}, 0);
      read_reg(reg_match_addr, 0, rd);
      expect_value("match", rd, 32'h0000FFFF);
      write_reg(reg_key_addr, {16'h0000, bg}, 3);
      read_reg(reg_match_addr, 0, rd);
      expect_value("match", rd, 32'h0);
      read_reg(reg_ctrl_addr, 4, rd);
      expect_value("ctrl", rd, {bg, 16'h0000});

      finish_run();
   end

endmodule

// File: verilog/bcam_array.sv
module bcam_array import cam_bist_pkg::*; (
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       we,
   input  cam_addr_t  waddr,
   input  cam_data_t  wdata,
   input  logic       search,
   input  cam_data_t  key,
   output cam_match_t match,
   output logic       match_valid
);
   cam_data_t  entry [cam_entries];
   cam_match_t hit;

   // --------------------------------------------------
   // Storage
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         // All entries start at zero
         for (int i = 0; i < cam_entries; i++) begin
            entry[i] <= '0;
         end
      end else if (we) begin
         entry[waddr] <= wdata;
      end
   end

   // --------------------------------------------------
   // Parallel compare
   // --------------------------------------------------
   always_comb begin
      for (int i = 0; i < cam_entries; i++) begin
         hit[i] = (entry[i] == key);
      end
   end

   // Valid pulses one cycle after the search strobe
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         match_valid <= 1'b0;
      end else begin
         match_valid <= search;
      end
   end

   // Result held until the next search
   always_ff @(posedge bist_clk) begin
      if (search) match <= hit;
   end

endmodule

// File: verilog/cam_bist_counter.sv
module cam_bist_counter import cam_bist_pkg::*; (
   input  logic      bist_clk,
   input  logic      rst_b,
   input  logic      cnt_clear,
   input  logic      addr_inc,
   input  logic      step_inc,
   output cam_addr_t addr,
   output bit_step_t step,
   output logic      addr_last,
   output logic      step_last
);

   // --------------------------------------------------
   // Entry and walking-step counters
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         addr <= '0;
         step <= '0;
      end else if (cnt_clear) begin
         addr <= '0;
         step <= '0;
      end else begin
         // Both wrap naturally at their width
         if (addr_inc) addr <= addr + 1'b1;
         if (step_inc) step <= step + 1'b1;
      end
   end

   // Terminal flags
   assign addr_last = (addr == cam_addr_t'(cam_entries - 1));
   assign step_last = (step == bit_step_t'(cam_width - 1));

endmodule

// File: verilog/cam_bist_fsm.sv
module cam_bist_fsm import cam_bist_pkg::*; (
   input  logic        bist_clk,
   input  logic        rst_b,
   input  logic        bist_start,
   input  logic        addr_last,
   input  logic        step_last,
   input  cam_match_t  match,
   input  logic        match_valid,
   output logic        busy,
   output logic        bist_done,
   output logic        bist_fail,
   output fail_count_t fail_count,
   output logic        bist_mode,
   output logic        mask_en,
   output logic        rotate,
   output logic        data_inv,
   output logic        bist_we,
   output logic        bist_search,
   output logic        cnt_clear,
   output logic        addr_inc,
   output logic        step_inc
);
   bist_state_t state;
   // Second pass uses the inverted background
   logic        pass;
   // Low for the all-match search, high for the walking searches
   logic        walk_phase;
   cam_match_t  expect_match;
   logic        mismatch;

   assign expect_match = walk_phase ? {cam_entries{1'b0}} : {cam_entries{1'b1}};
   assign mismatch     = (state == check) && match_valid && (match != expect_match);

   // --------------------------------------------------
   // Decoded controls
   // --------------------------------------------------
   assign busy        = (state != idle);
   assign bist_mode   = busy;
   assign data_inv    = pass;
   assign mask_en     = walk_phase;
   assign bist_we     = (state == write);
   assign addr_inc    = (state == write);
   assign bist_search = (state == search_all) || (state == search_walk);
   // Mask and step advance once each walking result is checked
   assign rotate      = (state == check) && walk_phase;
   assign step_inc    = (state == check) && walk_phase;
   assign cnt_clear   = ((state == idle) && bist_start) ||
                        ((state == check) && walk_phase && step_last && !pass);

   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state      <= idle;
         pass       <= 1'b0;
         walk_phase <= 1'b0;
         bist_done  <= 1'b0;
         bist_fail  <= 1'b0;
         fail_count <= '0;
      end else begin
         case (state)
            idle: begin
               if (bist_start) begin
                  state      <= write;
                  pass       <= 1'b0;
                  walk_phase <= 1'b0;
                  bist_done  <= 1'b0;
                  bist_fail  <= 1'b0;
                  fail_count <= '0;
               end
            end
            // One entry per cycle
            write:       if (addr_last) state <= search_all;
            search_all:  state <= check;
            search_walk: state <= check;
            check: begin
               if (!walk_phase) begin
                  walk_phase <= 1'b1;
                  state      <= search_walk;
               end else if (!step_last) begin
                  state <= search_walk;
               end else if (!pass) begin
                  // Rerun with inverted data
                  pass       <= 1'b1;
                  walk_phase <= 1'b0;
                  state      <= write;
               end else begin
                  state <= done;
               end
            end
            done: begin
               bist_done <= 1'b1;
               state     <= idle;
            end
            default: state <= idle;
         endcase
         // Sticky fail, saturating count
         if (mismatch) begin
            bist_fail <= 1'b1;
            if (fail_count != '1) fail_count <= fail_count + 1'b1;
         end
      end
   end

   a_we_search_excl: assert property (@(posedge bist_clk) disable iff (!rst_b)
      !(bist_we && bist_search));

endmodule

// File: verilog/cam_bist_inhandler.sv
module cam_bist_inhandler import cam_bist_pkg::*; (
   input  logic      bist_clk,
   input  logic      rst_b,
   input  logic      bist_mode,
   input  logic      mask_en,
   input  logic      rotate,
   input  logic      data_inv,
   input  cam_data_t background,
   input  cam_data_t fn_key,
   output cam_data_t wr_data,
   output cam_data_t key
);
   cam_data_t mask;
   cam_data_t compare_data;

   // --------------------------------------------------
   // Walking mask
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= cam_data_t'(1);
      end else if (rotate) begin
         // Rotate left, top bit back into bit 0
         mask <= {mask[cam_width-2:0], mask[cam_width-1]};
      end
   end

   // --------------------------------------------------
   // Data and key generation
   // --------------------------------------------------
   // Background or its inverse
   assign wr_data      = background ^ {cam_width{data_inv}};
   // One bit flipped when the mask is enabled
   assign compare_data = wr_data ^ (mask & {cam_width{mask_en}});
   assign key          = bist_mode ? compare_data : fn_key;

   a_mask_onehot: assert property (@(posedge bist_clk) disable iff (!rst_b)
      $onehot(mask));

endmodule

// File: verilog/cam_bist_pkg.sv
package cam_bist_pkg;

   // --------------------------------------------------
   // CAM geometry
   // --------------------------------------------------
   localparam int cam_entries = 16;
   localparam int cam_width   = 16;

   // One CAM word, also used for key, mask and compare data
   typedef logic [cam_width-1:0]           cam_data_t;
   typedef logic [$clog2(cam_entries)-1:0] cam_addr_t;
   // One hit bit per entry
   typedef logic [cam_entries-1:0]         cam_match_t;
   typedef logic [$clog2(cam_width)-1:0]   bit_step_t;
   typedef logic [7:0]                     fail_count_t;

   // --------------------------------------------------
   // Host register map
   // --------------------------------------------------
   typedef logic [4:0]  axi_addr_t;
   typedef logic [31:0] axi_data_t;

   localparam axi_addr_t reg_ctrl_addr   = 5'h00;
   localparam axi_addr_t reg_status_addr = 5'h04;
   localparam axi_addr_t reg_wdata_addr  = 5'h08;
   localparam axi_addr_t reg_key_addr    = 5'h0C;
   localparam axi_addr_t reg_match_addr  = 5'h10;

   // BIST sequencer states
   typedef enum logic [2:0] {idle, write, search_all, search_walk, check, done} bist_state_t;

endpackage

// File: verilog/cam_bist_regs.sv
module cam_bist_regs import cam_bist_pkg::*; (
   input  logic        bist_clk,
   input  logic        rst_b,
   input  logic        awvalid,
   output logic        awready,
   input  axi_addr_t   awaddr,
   input  logic        wvalid,
   output logic        wready,
   input  axi_data_t   wdata,
   input  logic [3:0]  wstrb,
   output logic        bvalid,
   input  logic        bready,
   output logic [1:0]  bresp,
   input  logic        arvalid,
   output logic        arready,
   input  axi_addr_t   araddr,
   output logic        rvalid,
   input  logic        rready,
   output axi_data_t   rdata,
   output logic [1:0]  rresp,
   input  logic        busy,
   input  logic        bist_done,
   input  logic        bist_fail,
   input  fail_count_t fail_count,
   input  cam_match_t  match,
   input  logic        match_valid,
   output logic        bist_start,
   output cam_data_t   background,
   output logic        fn_we,
   output cam_addr_t   fn_addr,
   output cam_data_t   fn_data,
   output logic        fn_search,
   output cam_data_t   fn_key
);
   logic       aw_hs;
   logic       ar_hs;
   logic       wr_ctrl;
   logic       wr_wdata;
   logic       wr_key;
   cam_match_t match_q;
   axi_data_t  rd_mux;

   // AW and W taken together, only with no response pending
   assign aw_hs   = awvalid && wvalid && !bvalid;
   assign awready = aw_hs;
   assign wready  = aw_hs;
   assign ar_hs   = arvalid && !rvalid;
   assign arready = !rvalid;
   // Always OKAY
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   assign wr_ctrl  = aw_hs && (awaddr == reg_ctrl_addr);
   assign wr_wdata = aw_hs && (awaddr == reg_wdata_addr);
   assign wr_key   = aw_hs && (awaddr == reg_key_addr);

   // --------------------------------------------------
   // Handshake state, strobes and status
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
         bist_start <= 1'b0;
         fn_we      <= 1'b0;
         fn_search  <= 1'b0;
         background <= '0;
         match_q    <= '0;
      end else begin
         if (aw_hs) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (ar_hs) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end
         // Host strobes are dropped while the engine owns the CAM
         bist_start <= wr_ctrl && wstrb[0] && wdata[0] && !busy;
         fn_we      <= wr_wdata && !busy;
         fn_search  <= wr_key && !busy;
         // Background frozen during a run
         if (wr_ctrl && !busy) begin
            if (wstrb[2]) background[7:0]  <= wdata[23:16];
            if (wstrb[3]) background[15:8] <= wdata[31:24];
         end
         // Last search result, functional or BIST
         if (match_valid) match_q <= match;
      end
   end

   // Write data and key payload
   always_ff @(posedge bist_clk) begin
      if (wr_wdata) begin
         if (wstrb[0]) fn_data[7:0]  <= wdata[7:0];
         if (wstrb[1]) fn_data[15:8] <= wdata[15:8];
         if (wstrb[2]) fn_addr       <= wdata[19:16];
      end
      if (wr_key) begin
         if (wstrb[0]) fn_key[7:0]  <= wdata[7:0];
         if (wstrb[1]) fn_key[15:8] <= wdata[15:8];
      end
      if (ar_hs) rdata <= rd_mux;
   end

   // --------------------------------------------------
   // Read mux
   // --------------------------------------------------
   always_comb begin
      case (araddr)
         reg_ctrl_addr:   rd_mux = {background, 16'h0000};
         reg_status_addr: rd_mux = {16'h0000, fail_count, 5'b00000, bist_fail, bist_done, busy};
         reg_wdata_addr:  rd_mux = {12'h000, fn_addr, fn_data};
         reg_key_addr:    rd_mux = {16'h0000, fn_key};
         // Bypass so a result is readable in the cycle it arrives
         reg_match_addr:  rd_mux = {16'h0000, match_valid ? match : match_q};
         default:         rd_mux = '0;
      endcase
   end

   // Write response held through back-pressure
   a_bvalid_hold: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bvalid && !bready |=> bvalid);

endmodule

// File: verilog/cam_bist_top.sv
module cam_bist_top import cam_bist_pkg::*; (
   input  logic       bist_clk,
   input  logic       rst_b,
   input  logic       awvalid,
   output logic       awready,
   input  axi_addr_t  awaddr,
   input  logic       wvalid,
   output logic       wready,
   input  axi_data_t  wdata,
   input  logic [3:0] wstrb,
   output logic       bvalid,
   input  logic       bready,
   output logic [1:0] bresp,
   input  logic       arvalid,
   output logic       arready,
   input  axi_addr_t  araddr,
   output logic       rvalid,
   input  logic       rready,
   output axi_data_t  rdata,
   output logic [1:0] rresp
);
   // Host side
   logic        bist_start;
   cam_data_t   background;
   logic        fn_we;
   cam_addr_t   fn_addr;
   cam_data_t   fn_data;
   logic        fn_search;
   cam_data_t   fn_key;
   // BIST engine
   logic        busy;
   logic        bist_done;
   logic        bist_fail;
   fail_count_t fail_count;
   logic        bist_mode;
   logic        mask_en;
   logic        rotate;
   logic        data_inv;
   logic        bist_we;
   logic        bist_search;
   logic        cnt_clear;
   logic        addr_inc;
   logic        step_inc;
   cam_addr_t   addr;
   bit_step_t   step;
   logic        addr_last;
   logic        step_last;
   cam_data_t   wr_data;
   cam_data_t   key;
   // CAM port
   logic        cam_we;
   cam_addr_t   cam_waddr;
   cam_data_t   cam_wdata;
   logic        cam_search;
   cam_match_t  match;
   logic        match_valid;

   // --------------------------------------------------
   // CAM source select, engine owns the array while busy
   // --------------------------------------------------
   assign cam_we     = busy ? bist_we : fn_we;
   assign cam_waddr  = busy ? addr : fn_addr;
   assign cam_wdata  = busy ? wr_data : fn_data;
   assign cam_search = busy ? bist_search : fn_search;

   cam_bist_regs u_regs (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .awvalid     (awvalid),
      .awready     (awready),
      .awaddr      (awaddr),
      .wvalid      (wvalid),
      .wready      (wready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .bvalid      (bvalid),
      .bready      (bready),
      .bresp       (bresp),
      .arvalid     (arvalid),
      .arready     (arready),
      .araddr      (araddr),
      .rvalid      (rvalid),
      .rready      (rready),
      .rdata       (rdata),
      .rresp       (rresp),
      .busy        (busy),
      .bist_done   (bist_done),
      .bist_fail   (bist_fail),
      .fail_count  (fail_count),
      .match       (match),
      .match_valid (match_valid),
      .bist_start  (bist_start),
      .background  (background),
      .fn_we       (fn_we),
      .fn_addr     (fn_addr),
      .fn_data     (fn_data),
      .fn_search   (fn_search),
      .fn_key      (fn_key)
   );

   cam_bist_fsm u_fsm (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .bist_start  (bist_start),
      .addr_last   (addr_last),
      .step_last   (step_last),
      .match       (match),
      .match_valid (match_valid),
      .busy        (busy),
      .bist_done   (bist_done),
      .bist_fail   (bist_fail),
      .fail_count  (fail_count),
      .bist_mode   (bist_mode),
      .mask_en     (mask_en),
      .rotate      (rotate),
      .data_inv    (data_inv),
      .bist_we     (bist_we),
      .bist_search (bist_search),
      .cnt_clear   (cnt_clear),
      .addr_inc    (addr_inc),
      .step_inc    (step_inc)
   );

   cam_bist_counter u_counter (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .cnt_clear (cnt_clear),
      .addr_inc  (addr_inc),
      .step_inc  (step_inc),
      .addr      (addr),
      .step      (step),
      .addr_last (addr_last),
      .step_last (step_last)
   );

   cam_bist_inhandler u_inhandler (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .bist_mode  (bist_mode),
      .mask_en    (mask_en),
      .rotate     (rotate),
      .data_inv   (data_inv),
      .background (background),
      .fn_key     (fn_key),
      .wr_data    (wr_data),
      .key        (key)
   );

   bcam_array u_cam (
      .bist_clk    (bist_clk),
      .rst_b       (rst_b),
      .we          (cam_we),
      .waddr       (cam_waddr),
      .wdata       (cam_wdata),
      .search      (cam_search),
      .key         (key),
      .match       (match),
      .match_valid (match_valid)
   );

   // Walking key differs from the written data only at the current step bit
   a_walk_bit: assert property (@(posedge bist_clk) disable iff (!rst_b)
      bist_search && mask_en |-> (key ^ wr_data) == (cam_data_t'(1) << step));

endmodule
